//--- cache_be_pkg.sv
`default_nettype none

package cache_be_pkg;

   localparam int FE_ADDR_W     = 16; // byte address on the cache side
   localparam int DATA_W        = 32; // same word on both sides
   localparam int NBYTES_W      = 2;
   localparam int WORD_OFFSET_W = 2;  // four words per line
   localparam int LINE_ADDR_W   = FE_ADDR_W - WORD_OFFSET_W - NBYTES_W;
   localparam int BE_ADDR_W     = 16; // memory port byte address

   typedef logic [FE_ADDR_W-1:0]     addr_t;
   typedef logic [LINE_ADDR_W-1:0]   line_addr_t;
   typedef logic [WORD_OFFSET_W-1:0] word_off_t;
   typedef logic [DATA_W-1:0]        data_t;
   typedef logic [DATA_W/8-1:0]      wstrb_t; // all zeros is a read

   // line refill
   typedef enum logic [1:0] {
      rd_idle,
      rd_xfer,
      rd_end
   } rd_state_t;

   // write-through buffer
   typedef enum logic {
      wr_empty,
      wr_busy
   } wr_state_t;

   // memory port owner
   typedef enum logic [1:0] {
      own_none,
      own_rd,
      own_wr
   } own_t;

endpackage

`default_nettype wire

//--- cache_read_channel.sv
`timescale 1ns/1ps
`default_nettype none

module cache_read_channel import cache_be_pkg::*; (
   input  wire        clk_i,
   input  wire        arst_i,

   // line request from the controller
   input  wire        read_valid_i,
   input  line_addr_t read_addr_i,

   // word strobes back to the controller
   output logic       read_valid_o,
   output word_off_t  read_addr_o,
   output logic       rd_busy_o,

   // towards the arbiter
   output logic       be_valid_o,
   output addr_t      be_addr_o,
   input  wire        be_ready_i,
   input  wire        be_rvalid_i
);

   rd_state_t state_q;
   word_off_t word_q;    // offset of the next word to come back
   word_off_t word_cnt;
   logic      last_word;

   assign rd_busy_o = (state_q != rd_idle);

   // offset 3 is returning now
   assign last_word = be_rvalid_i & (&word_q);

   // line address, word offset, zero byte bits
   assign be_addr_o = {read_addr_i, word_cnt, {NBYTES_W{1'b0}}};

   always_comb begin
      be_valid_o   = 1'b0;
      read_valid_o = 1'b0;
      word_cnt     = '0;
      case (state_q)
         rd_xfer: begin
            be_valid_o   = ~last_word; // keep asking until the last word is back
            read_valid_o = be_rvalid_i;
            word_cnt     = word_q + word_off_t'(be_rvalid_i);
         end
         default: begin
            be_valid_o   = 1'b0;
            read_valid_o = 1'b0;
            word_cnt     = '0;
         end
      endcase
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q <= rd_idle;
         word_q  <= '0;
      end else begin
         word_q <= word_cnt;
         case (state_q)
            rd_idle: begin
               if (read_valid_i && be_ready_i) begin
                  state_q <= rd_xfer;
               end
            end
            rd_xfer: begin
               if (last_word) begin
                  state_q <= rd_end;
               end
            end
            rd_end: begin
               state_q <= rd_idle; // one cycle to let the caller drop its request
            end
            default: begin
               state_q <= rd_idle;
            end
         endcase
      end
   end

   // offset of the word just strobed, visible the cycle after
   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         read_addr_o <= '0;
      end else if (read_valid_o) begin
         read_addr_o <= word_q;
      end
   end

endmodule

`default_nettype wire

//--- cache_write_channel.sv
`timescale 1ns/1ps
`default_nettype none

module cache_write_channel import cache_be_pkg::*; (
   input  wire    clk_i,
   input  wire    arst_i,

   // write-through word from the controller
   input  wire    write_valid_i,
   input  addr_t  write_addr_i,
   input  data_t  write_wdata_i,
   input  wstrb_t write_wstrb_i,
   output logic   write_ready_o,

   // towards the arbiter
   output logic   be_valid_o,
   output addr_t  be_addr_o,
   output data_t  be_wdata_o,
   output wstrb_t be_wstrb_o,
   input  wire    be_ready_i
);

   wr_state_t state_q;
   addr_t     addr_q;
   data_t     wdata_q;
   wstrb_t    wstrb_q;
   logic      accept;

   assign write_ready_o = (state_q == wr_empty);

   // a word with no byte enabled changes nothing, so it is dropped
   assign accept = write_ready_o & write_valid_i & (|write_wstrb_i);

   assign be_valid_o = (state_q == wr_busy);
   assign be_addr_o  = addr_q;
   assign be_wdata_o = wdata_q;
   assign be_wstrb_o = wstrb_q;

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q <= wr_empty;
      end else begin
         case (state_q)
            wr_empty: begin
               if (accept) begin
                  state_q <= wr_busy;
               end
            end
            wr_busy: begin
               if (be_ready_i) begin
                  state_q <= wr_empty; // taken by memory, buffer frees next cycle
               end
            end
            default: begin
               state_q <= wr_empty;
            end
         endcase
      end
   end

   // single entry buffer
   always_ff @(posedge clk_i) begin
      if (accept) begin
         addr_q  <= {write_addr_i[FE_ADDR_W-1:NBYTES_W], {NBYTES_W{1'b0}}}; // word aligned
         wdata_q <= write_wdata_i;
         wstrb_q <= write_wstrb_i;
      end
   end

endmodule

`default_nettype wire

//--- cache_be_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module cache_be_arbiter import cache_be_pkg::*; (
   input  wire                  clk_i,
   input  wire                  arst_i,

   // read channel
   input  wire                  rd_valid_i,
   input  addr_t                rd_addr_i,
   input  wire                  rd_busy_i,
   output logic                 rd_ready_o,
   output logic                 rd_rvalid_o,

   // write channel
   input  wire                  wr_valid_i,
   input  addr_t                wr_addr_i,
   input  data_t                wr_wdata_i,
   input  wstrb_t               wr_wstrb_i,
   output logic                 wr_ready_o,

   // memory port
   output logic                 be_valid_o,
   output logic [BE_ADDR_W-1:0] be_addr_o,
   output data_t                be_wdata_o,
   output wstrb_t               be_wstrb_o,
   input  wire                  be_ready_i,
   input  wire                  be_rvalid_i
);

   own_t own_q;
   own_t own_d;
   own_t sel;

   // owner this cycle, a locked owner keeps the port
   always_comb begin
      case (own_q)
         own_rd: sel = own_rd;
         own_wr: sel = own_wr;
         default: begin
            if (wr_valid_i) begin
               sel = own_wr; // write wins a tie so refills see it
            end else if (rd_valid_i) begin
               sel = own_rd;
            end else begin
               sel = own_none;
            end
         end
      endcase
   end

   always_comb begin
      case (sel)
         own_rd:  own_d = rd_busy_i ? own_rd : own_none; // hold for the whole line
         own_wr:  own_d = (wr_valid_i && !be_ready_i) ? own_wr : own_none;
         default: own_d = own_none;
      endcase
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         own_q <= own_none;
      end else begin
         own_q <= own_d;
      end
   end

   always_comb begin
      be_valid_o = 1'b0;
      be_addr_o  = BE_ADDR_W'(rd_addr_i);
      be_wdata_o = '0;
      be_wstrb_o = '0; // zero strobe makes it a read
      case (sel)
         own_rd: be_valid_o = rd_valid_i;
         own_wr: begin
            be_valid_o = wr_valid_i;
            be_addr_o  = BE_ADDR_W'(wr_addr_i);
            be_wdata_o = wr_wdata_i;
            be_wstrb_o = wr_wstrb_i;
         end
         default: be_valid_o = 1'b0;
      endcase
   end

   // an idle port is offered to the read side so it can start a line
   assign rd_ready_o  = be_ready_i & (sel != own_wr);
   assign rd_rvalid_o = be_rvalid_i & (sel == own_rd);
   assign wr_ready_o  = be_ready_i & (sel == own_wr);

endmodule

`default_nettype wire

//--- cache_back_end.sv
`timescale 1ns/1ps
`default_nettype none

module cache_back_end import cache_be_pkg::*; (
   input  wire                  clk_i,
   input  wire                  arst_i,

   // line refill
   input  wire                  read_valid_i,
   input  line_addr_t           read_addr_i,
   output logic                 read_valid_o,
   output word_off_t            read_addr_o,
   output data_t                read_rdata_o,

   // write-through
   input  wire                  write_valid_i,
   input  addr_t                write_addr_i,
   input  data_t                write_wdata_i,
   input  wstrb_t               write_wstrb_i,
   output logic                 write_ready_o,

   // memory port
   output logic                 be_valid_o,
   output logic [BE_ADDR_W-1:0] be_addr_o,
   output data_t                be_wdata_o,
   output wstrb_t               be_wstrb_o,
   input  wire                  be_ready_i,
   input  wire                  be_rvalid_i,
   input  data_t                be_rdata_i
);

   logic   rd_be_valid;
   addr_t  rd_be_addr;
   logic   rd_busy;
   logic   rd_ready;
   logic   rd_rvalid;

   logic   wr_be_valid;
   addr_t  wr_be_addr;
   data_t  wr_be_wdata;
   wstrb_t wr_be_wstrb;
   logic   wr_ready;

   assign read_rdata_o = be_rdata_i; // same cycle as the read strobe

   cache_read_channel u_rd (
      .clk_i        (clk_i),
      .arst_i       (arst_i),
      .read_valid_i (read_valid_i),
      .read_addr_i  (read_addr_i),
      .read_valid_o (read_valid_o),
      .read_addr_o  (read_addr_o),
      .rd_busy_o    (rd_busy),
      .be_valid_o   (rd_be_valid),
      .be_addr_o    (rd_be_addr),
      .be_ready_i   (rd_ready),
      .be_rvalid_i  (rd_rvalid)
   );

   cache_write_channel u_wr (
      .clk_i         (clk_i),
      .arst_i        (arst_i),
      .write_valid_i (write_valid_i),
      .write_addr_i  (write_addr_i),
      .write_wdata_i (write_wdata_i),
      .write_wstrb_i (write_wstrb_i),
      .write_ready_o (write_ready_o),
      .be_valid_o    (wr_be_valid),
      .be_addr_o     (wr_be_addr),
      .be_wdata_o    (wr_be_wdata),
      .be_wstrb_o    (wr_be_wstrb),
      .be_ready_i    (wr_ready)
   );

   cache_be_arbiter u_arb (
      .clk_i       (clk_i),
      .arst_i      (arst_i),
      .rd_valid_i  (rd_be_valid),
      .rd_addr_i   (rd_be_addr),
      .rd_busy_i   (rd_busy),
      .rd_ready_o  (rd_ready),
      .rd_rvalid_o (rd_rvalid),
      .wr_valid_i  (wr_be_valid),
      .wr_addr_i   (wr_be_addr),
      .wr_wdata_i  (wr_be_wdata),
      .wr_wstrb_i  (wr_be_wstrb),
      .wr_ready_o  (wr_ready),
      .be_valid_o  (be_valid_o),
      .be_addr_o   (be_addr_o),
      .be_wdata_o  (be_wdata_o),
      .be_wstrb_o  (be_wstrb_o),
      .be_ready_i  (be_ready_i),
      .be_rvalid_i (be_rvalid_i)
   );

endmodule

`default_nettype wire

//--- cache_back_end_sva.sv
`timescale 1ns/1ps
`default_nettype none

module cache_back_end_sva import cache_be_pkg::*; (
   input wire                  clk_i,
   input wire                  arst_i,
   input wire                  be_valid_i,
   input wire [BE_ADDR_W-1:0]  be_addr_i,
   input wstrb_t               be_wstrb_i,
   input wire                  be_ready_i,
   input wire                  read_valid_i,
   input wire                  write_ready_i,
   input wire                  rd_busy_i
);

   // stalled request holds still
   assert property (@(posedge clk_i) disable iff (arst_i)
      be_valid_i && !be_ready_i |=> be_valid_i && $stable(be_addr_i) && $stable(be_wstrb_i))
      else $error("memory request changed while stalled");

   assert property (@(posedge clk_i) disable iff (arst_i)
      read_valid_i |-> $past(be_valid_i && be_ready_i && be_wstrb_i == 4'h0))
      else $error("read strobe without an accepted read request");

   // once a line is in flight the read side keeps the port
   assert property (@(posedge clk_i) disable iff (arst_i)
      be_valid_i && be_ready_i && be_wstrb_i == 4'h0 |=>
         !(rd_busy_i && be_valid_i && be_wstrb_i != 4'h0))
      else $error("write request during a locked line refill");

   assert property (@(posedge clk_i) $fell(arst_i) |-> write_ready_i)
      else $error("write buffer not empty after reset");

endmodule

bind cache_back_end cache_back_end_sva u_sva (
   .clk_i         (clk_i),
   .arst_i        (arst_i),
   .be_valid_i    (be_valid_o),
   .be_addr_i     (be_addr_o),
   .be_wstrb_i    (be_wstrb_o),
   .be_ready_i    (be_ready_i),
   .read_valid_i  (read_valid_o),
   .write_ready_i (write_ready_o),
   .rd_busy_i     (rd_busy)
);

`default_nettype wire

//--- tb_cache_back_end.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cache_back_end import cache_be_pkg::*; ();

   localparam int TIMEOUT_CYC = 200;
   localparam int N_ENTRY     = 16;
   localparam logic [1:0] OP_RD      = 2'd0;
   localparam logic [1:0] OP_WR      = 2'd1;
   localparam logic [1:0] OP_BOTH    = 2'd2;
   localparam logic [1:0] OP_LATE_WR = 2'd3; // write arrives while the line is in flight

   logic                 clk = 1'b0;
   logic                 arst;
   logic                 read_valid;
   line_addr_t           read_addr;
   logic                 read_valid_o;
   word_off_t            read_addr_o;
   data_t                read_rdata_o;
   logic                 write_valid;
   addr_t                write_addr;
   data_t                write_wdata;
   wstrb_t               write_wstrb;
   logic                 write_ready_o;
   logic                 be_valid_o;
   logic [BE_ADDR_W-1:0] be_addr_o;
   data_t                be_wdata_o;
   wstrb_t               be_wstrb_o;
   logic                 be_ready;
   logic                 be_rvalid;
   data_t                be_rdata;

   logic [31:0] lcg_state;
   data_t       mem [1024];     // memory model
   data_t       ref_mem [1024]; // expected contents
   wstrb_t      acc_log [$];    // strobe of every accepted port request
   int          errors;
   int          timeouts;

   logic [1:0]  tbl_op   [N_ENTRY];
   line_addr_t  tbl_line [N_ENTRY];
   addr_t       tbl_addr [N_ENTRY];
   data_t       tbl_data [N_ENTRY];
   wstrb_t      tbl_strb [N_ENTRY];

   always #5 clk = ~clk;

   cache_back_end u_dut (
      .clk_i         (clk),
      .arst_i        (arst),
      .read_valid_i  (read_valid),
      .read_addr_i   (read_addr),
      .read_valid_o  (read_valid_o),
      .read_addr_o   (read_addr_o),
      .read_rdata_o  (read_rdata_o),
      .write_valid_i (write_valid),
      .write_addr_i  (write_addr),
      .write_wdata_i (write_wdata),
      .write_wstrb_i (write_wstrb),
      .write_ready_o (write_ready_o),
      .be_valid_o    (be_valid_o),
      .be_addr_o     (be_addr_o),
      .be_wdata_o    (be_wdata_o),
      .be_wstrb_o    (be_wstrb_o),
      .be_ready_i    (be_ready),
      .be_rvalid_i   (be_rvalid),
      .be_rdata_i    (be_rdata)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   // initial content, every address bit takes part
   function automatic data_t mix_word(input int idx);
      logic [31:0] x;
      x = idx;
      return (x * 32'h9e3779b1) ^ {x[15:0], ~x[15:0]};
   endfunction

   function automatic data_t merge_bytes(input data_t old_w, input data_t new_w, input wstrb_t s);
      data_t r;
      r = old_w;
      for (int b = 0; b < 4; b++) begin
         if (s[b]) r[b*8 +: 8] = new_w[b*8 +: 8];
      end
      return r;
   endfunction

   // random stalls, about one cycle in four
   always @(posedge clk or posedge arst) begin
      if (arst) begin
         lcg_state <= 32'h7d06;
         be_ready  <= 1'b0;
      end else begin
         lcg_state <= lcg_next(lcg_state);
         be_ready  <= (lcg_state[17:16] != 2'b00);
      end
   end

   always @(posedge clk or posedge arst) begin
      if (arst) begin
         be_rvalid <= 1'b0;
         be_rdata  <= '0;
         for (int i = 0; i < 1024; i++) mem[i] <= mix_word(i);
      end else begin
         be_rvalid <= 1'b0;
         if (be_valid_o && be_ready) begin
            acc_log.push_back(be_wstrb_o);
            if (be_wstrb_o == 4'h0) begin
               be_rvalid <= 1'b1; // data one cycle after acceptance
               be_rdata  <= mem[be_addr_o[11:2]];
            end else begin
               mem[be_addr_o[11:2]] <= merge_bytes(mem[be_addr_o[11:2]], be_wdata_o, be_wstrb_o);
            end
         end
      end
   end

   task automatic set_entry(input int i, input logic [1:0] op, input line_addr_t line,
                            input addr_t addr, input data_t data, input wstrb_t strb);
      tbl_op[i]   = op;
      tbl_line[i] = line;
      tbl_addr[i] = addr;
      tbl_data[i] = data;
      tbl_strb[i] = strb;
   endtask

   task automatic wait_write_ready();
      int n;
      n = 0;
      @(negedge clk);
      while (!write_ready_o && n < TIMEOUT_CYC) begin
         @(negedge clk);
         n++;
      end
      if (!write_ready_o) begin
         timeouts++;
         $display("timeout: write_ready_o never came back high");
      end
   endtask

   // four strobes, checked against the reference memory
   task automatic collect_line(input line_addr_t line);
      int        n;
      int        cnt;
      logic      pend;
      word_off_t exp_off;
      data_t     exp_w;
      n = 0;
      cnt = 0;
      pend = 1'b0;
      exp_off = '0;
      while (cnt < 4 && n < TIMEOUT_CYC) begin
         @(negedge clk);
         n++;
         if (pend) begin
            if (read_addr_o !== exp_off) begin
               errors++;
               $display("mismatch read_addr_o: got %h expected %h", read_addr_o, exp_off);
            end
            pend = 1'b0;
         end
         if (read_valid_o) begin
            exp_w = ref_mem[{line[7:0], cnt[1:0]}];
            if (read_rdata_o !== exp_w) begin
               errors++;
               $display("mismatch read_rdata_o: got %h expected %h", read_rdata_o, exp_w);
            end
            exp_off = cnt[1:0];
            pend = 1'b1;
            cnt++;
         end
      end
      @(posedge clk);
      read_valid <= 1'b0;
      if (cnt < 4) begin
         timeouts++;
         $display("timeout: line read got only %0d of 4 words", cnt);
      end else begin
         @(negedge clk);
         if (read_addr_o !== exp_off) begin
            errors++;
            $display("mismatch read_addr_o: got %h expected %h", read_addr_o, exp_off);
         end
         repeat (3) begin
            @(negedge clk);
            if (read_valid_o) begin
               errors++;
               $display("extra read_valid_o strobe after the last word of the line");
            end
         end
      end
   endtask

   task automatic run_write(input addr_t addr, input data_t data, input wstrb_t strb);
      wait_write_ready();
      if (timeouts == 0) begin
         @(posedge clk);
         write_valid <= 1'b1;
         write_addr  <= addr;
         write_wdata <= data;
         write_wstrb <= strb;
         @(posedge clk);
         write_valid <= 1'b0;
         ref_mem[addr[11:2]] = merge_bytes(ref_mem[addr[11:2]], data, strb);
         wait_write_ready();
      end
   endtask

   task automatic run_read(input line_addr_t line);
      @(posedge clk);
      read_valid <= 1'b1;
      read_addr  <= line;
      collect_line(line);
   endtask

   task automatic run_both(input line_addr_t line, input addr_t addr, input data_t data,
                           input wstrb_t strb);
      int start;
      wait_write_ready();
      if (timeouts == 0) begin
         start = acc_log.size();
         @(posedge clk);
         write_valid <= 1'b1;
         write_addr  <= addr;
         write_wdata <= data;
         write_wstrb <= strb;
         read_valid  <= 1'b1;
         read_addr   <= line;
         ref_mem[addr[11:2]] = merge_bytes(ref_mem[addr[11:2]], data, strb); // write goes first
         @(posedge clk);
         write_valid <= 1'b0;
         collect_line(line);
         if (acc_log.size() <= start) begin
            errors++;
            $display("no request reached the memory port for the combined operation");
         end else if (acc_log[start] == 4'h0) begin
            errors++;
            $display("read reached the memory port before the pending write");
         end
         wait_write_ready();
      end
   endtask

   // the line owns the port, so a write issued after the first word lands after the refill
   task automatic read_with_late_write(input line_addr_t line, input addr_t addr,
                                       input data_t data, input wstrb_t strb);
      int n;
      wait_write_ready();
      if (timeouts == 0) begin
         @(posedge clk);
         read_valid <= 1'b1;
         read_addr  <= line;
         fork
            collect_line(line);
            begin
               n = 0;
               @(negedge clk);
               while (!read_valid_o && n < TIMEOUT_CYC) begin
                  @(negedge clk);
                  n++;
               end
               @(posedge clk);
               write_valid <= 1'b1;
               write_addr  <= addr;
               write_wdata <= data;
               write_wstrb <= strb;
               @(posedge clk);
               write_valid <= 1'b0;
            end
         join
         ref_mem[addr[11:2]] = merge_bytes(ref_mem[addr[11:2]], data, strb);
         wait_write_ready();
      end
   endtask

   initial begin
      errors = 0;
      timeouts = 0;
      arst        <= 1'b1;
      read_valid  <= 1'b0;
      read_addr   <= '0;
      write_valid <= 1'b0;
      write_addr  <= '0;
      write_wdata <= '0;
      write_wstrb <= '0;
      for (int i = 0; i < 1024; i++) ref_mem[i] = mix_word(i);

      set_entry(0,  OP_RD,   12'h010, 16'h0000, 32'h0000_0000, 4'h0);
      set_entry(1,  OP_WR,   12'h000, 16'h0104, 32'hdead_beef, 4'hf);
      set_entry(2,  OP_RD,   12'h010, 16'h0000, 32'h0000_0000, 4'h0);
      set_entry(3,  OP_WR,   12'h000, 16'h0108, 32'h1122_3344, 4'h5);
      set_entry(4,  OP_RD,   12'h010, 16'h0000, 32'h0000_0000, 4'h0);
      set_entry(5,  OP_BOTH, 12'h020, 16'h020c, 32'hcafe_f00d, 4'h3);
      set_entry(6,  OP_WR,   12'h000, 16'h0300, 32'ha5a5_a5a5, 4'h8);
      set_entry(7,  OP_RD,   12'h030, 16'h0000, 32'h0000_0000, 4'h0);
      set_entry(8,  OP_BOTH, 12'h030, 16'h0304, 32'h0bad_c0de, 4'hf);
      set_entry(9,  OP_RD,   12'h0ff, 16'h0000, 32'h0000_0000, 4'h0);
      set_entry(10, OP_WR,   12'h000, 16'h0ff8, 32'h1234_5678, 4'h6);
      set_entry(11, OP_RD,   12'h0ff, 16'h0000, 32'h0000_0000, 4'h0);
      set_entry(12, OP_BOTH, 12'h044, 16'h0440, 32'h89ab_cdef, 4'h9);
      set_entry(13, OP_LATE_WR, 12'h001, 16'h001c, 32'h5a5a_0f0f, 4'hc);
      set_entry(14, OP_WR,   12'h000, 16'h0014, 32'hfedc_ba98, 4'h2);
      set_entry(15, OP_RD,   12'h001, 16'h0000, 32'h0000_0000, 4'h0);

      repeat (4) @(posedge clk);
      arst <= 1'b0;

      @(negedge clk);
      if (read_valid_o !== 1'b0) begin
         errors++;
         $display("mismatch read_valid_o: got %h expected %h", read_valid_o, 1'b0);
      end
      if (be_valid_o !== 1'b0) begin
         errors++;
         $display("mismatch be_valid_o: got %h expected %h", be_valid_o, 1'b0);
      end
      if (write_ready_o !== 1'b1) begin
         errors++;
         $display("mismatch write_ready_o: got %h expected %h", write_ready_o, 1'b1);
      end

      for (int e = 0; e < N_ENTRY; e++) begin
         case (tbl_op[e])
            OP_RD:   run_read(tbl_line[e]);
            OP_WR:   run_write(tbl_addr[e], tbl_data[e], tbl_strb[e]);
            OP_BOTH: run_both(tbl_line[e], tbl_addr[e], tbl_data[e], tbl_strb[e]);
            default: read_with_late_write(tbl_line[e], tbl_addr[e], tbl_data[e], tbl_strb[e]);
         endcase
         if (timeouts != 0) break;
      end

      repeat (5) @(posedge clk);
      $display("checks done: %0d mismatches, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- src.f
cache_be_pkg.sv
cache_read_channel.sv
cache_write_channel.sv
cache_be_arbiter.sv
cache_back_end.sv
cache_back_end_sva.sv
tb_cache_back_end.sv

//--- run_sim.sh
#!/bin/sh
# build and run the cache back-end testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
   -f src.f \
   --top-module tb_cache_back_end \
   -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || {
   cat sim.log
   exit 1
}
cat sim.log

if grep -q "Simulation PASSED" sim.log; then
   exit 0
else
   exit 1
fi
